// ==== common/div_if.sv ====
`timescale 1ns/1ps

interface div_if
    import div_pkg::*;
();

    logic      start;          // Single-cycle pulse
    dividend_t dividend;
    divisor_t  divisor;
    logic      inputs_signed;

    quotient_t quotient;
    quotient_t remainder;
    logic      busy;
    logic      done;           // One cycle, results valid
    logic      div_zero;
    logic      sign_overflow;

    modport regs (
        output start,
        output dividend,
        output divisor,
        output inputs_signed,
        input  quotient,
        input  remainder,
        input  busy,
        input  done,
        input  div_zero,
        input  sign_overflow
    );

    modport core (
        input  start,
        input  dividend,
        input  divisor,
        input  inputs_signed,
        output quotient,
        output remainder,
        output busy,
        output done,
        output div_zero,
        output sign_overflow
    );

endinterface

// ==== common/div_pkg.sv ====
package div_pkg;

    // Operand and result width, fixed for this peripheral
    localparam int data_width = 32;

    // One restoring step per quotient bit
    localparam int iter_count = 32;
    localparam int step_width = $clog2(iter_count);
    localparam logic [step_width-1:0] last_step = step_width'(iter_count - 1);

    typedef logic [data_width-1:0]   dividend_t;
    typedef logic [data_width-1:0]   divisor_t;
    typedef logic [data_width-1:0]   quotient_t;
    typedef logic [2*data_width-1:0] remainder_t;  // Partial remainder above, quotient below

    // Register map, byte addresses
    localparam logic [31:0] reg_dividend  = 32'h00;
    localparam logic [31:0] reg_divisor   = 32'h04;
    localparam logic [31:0] reg_ctrl      = 32'h08;
    localparam logic [31:0] reg_status    = 32'h0C;
    localparam logic [31:0] reg_quotient  = 32'h10;
    localparam logic [31:0] reg_remainder = 32'h14;

    // Command word
    localparam int ctrl_start_bit  = 0;
    localparam int ctrl_signed_bit = 1;

    // Status word
    localparam int status_busy_bit     = 0;
    localparam int status_done_bit     = 1;
    localparam int status_div_zero_bit = 2;
    localparam int status_overflow_bit = 3;

    // Sequencer states
    localparam logic [1:0] state_idle    = 2'd0;
    localparam logic [1:0] state_iterate = 2'd1;
    localparam logic [1:0] state_finish  = 2'd2;

endpackage

// ==== divider/divider.sv ====
`timescale 1ns/1ps

module divider
    import div_pkg::*;
(
    input logic clk,
    input logic rst_n,
    div_if.core core
);

    dividend_t  dvd_mag_in;
    divisor_t   dsr_mag_in;
    dividend_t  dvd_mag;
    divisor_t   dsr_mag;
    logic       dvd_neg;
    logic       dsr_neg;
    logic       signed_q;
    logic       init;
    logic       load_remainder;
    remainder_t rem_q;
    remainder_t rem_next;
    remainder_t rem_step;
    quotient_t  quo_mag;
    quotient_t  rem_mag;
    logic       quo_neg;
    logic       ctl_zero;
    logic       ctl_ovf;
    logic       sign_ovf;
    logic       exception;
    logic       ctl_busy;
    logic       ctl_done;
    logic       busy_q;
    logic       done_q;

    function automatic logic [data_width-1:0] magnitude(
        input logic [data_width-1:0] value,
        input logic                  is_signed
    );
        return (is_signed && value[data_width-1]) ? -value : value;
    endfunction

    assign dvd_mag_in = magnitude(core.dividend, core.inputs_signed);
    assign dsr_mag_in = magnitude(core.divisor, core.inputs_signed);

    // Zero above the dividend magnitude on the load cycle
    assign rem_next = init ? {{data_width{1'b0}}, dvd_mag_in} : rem_step;

    always_ff @(posedge clk) begin
        if (init) begin
            dvd_mag  <= dvd_mag_in;
            dsr_mag  <= dsr_mag_in;
            dvd_neg  <= core.inputs_signed && core.dividend[data_width-1];
            dsr_neg  <= core.inputs_signed && core.divisor[data_width-1];
            signed_q <= core.inputs_signed;
        end
        if (load_remainder)
            rem_q <= rem_next;
    end

    divider_control u_control (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (core.start),
        .dividend       (dvd_mag),
        .divisor        (dsr_mag),
        .remainder_in   (rem_q),
        .inputs_signed  (signed_q),
        .init           (init),
        .load_remainder (load_remainder),
        .remainder_out  (rem_step),
        .div_zero       (ctl_zero),
        .sign_overflow  (ctl_ovf),
        .busy           (ctl_busy),
        .done           (ctl_done)
    );

    // Output register stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            busy_q <= ctl_busy;
            done_q <= ctl_done;
        end
    end

    // Only -1 makes the magnitude pattern a true overflow
    assign sign_ovf  = ctl_ovf && dsr_neg;
    assign exception = ctl_zero || sign_ovf;

    assign quo_mag = rem_q[data_width-1:0];
    assign rem_mag = rem_q[2*data_width-1:data_width];
    assign quo_neg = dvd_neg ^ dsr_neg;

    assign core.quotient      = (quo_neg && !exception) ? -quo_mag : quo_mag;
    assign core.remainder     = dvd_neg ? -rem_mag : rem_mag;  // Sign follows dividend
    assign core.busy          = busy_q;
    assign core.done          = done_q;
    assign core.div_zero      = ctl_zero;
    assign core.sign_overflow = sign_ovf;

    a_div_identity: assert property (@(posedge clk) disable iff (!rst_n)
        core.done && !exception |->
            ({32'b0, quo_mag} * {32'b0, dsr_mag}) + {32'b0, rem_mag} == {32'b0, dvd_mag});

endmodule

// ==== divider/divider_control.sv ====
`timescale 1ns/1ps

module divider_control
    import div_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  dividend_t  dividend,
    input  divisor_t   divisor,
    input  remainder_t remainder_in,
    input  logic       inputs_signed,
    output logic       init,
    output logic       load_remainder,
    output remainder_t remainder_out,
    output logic       div_zero,
    output logic       sign_overflow,
    output logic       busy,
    output logic       done
);

    logic [1:0]            state;
    logic [step_width-1:0] step;
    logic                  last;
    logic [data_width:0]   trial;
    remainder_t            step_value;
    remainder_t            forced;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= state_idle;
            step  <= '0;
        end else begin
            case (state)
                state_idle: begin
                    step <= '0;
                    if (start)
                        state <= state_iterate;
                end
                state_iterate: begin
                    step <= step + 1'b1;
                    if (step == last_step)
                        state <= state_finish;
                end
                default: state <= state_idle;
            endcase
        end
    end

    assign init           = (state == state_idle) && start;
    assign load_remainder = init || (state == state_iterate);
    assign last           = (state == state_iterate) && (step == last_step);
    assign busy           = init || (state == state_iterate);
    assign done           = (state == state_finish);

    // Shifted partial remainder is 33 bits wide before the trial subtract
    assign trial = remainder_in[2*data_width-1:data_width-1] - {1'b0, divisor};

    always_comb begin
        if (!trial[data_width])
            step_value = {trial[data_width-1:0], remainder_in[data_width-2:0], 1'b1};
        else
            step_value = {remainder_in[2*data_width-2:0], 1'b0};
    end

    assign div_zero      = (divisor == '0);
    assign sign_overflow = inputs_signed && (divisor == divisor_t'(1))
                           && (dividend == {1'b1, {(data_width-1){1'b0}}});

    // RISC-V results for the two corner cases
    always_comb begin
        if (div_zero)
            forced = {dividend, {data_width{1'b1}}};
        else
            forced = {{data_width{1'b0}}, 1'b1, {(data_width-1){1'b0}}};
    end

    assign remainder_out = (last && (div_zero || sign_overflow)) ? forced : step_value;

    a_busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done));

    a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        init |-> ##(iter_count + 1) done);

endmodule

// ==== project.f ====
+incdir+tests
common/div_pkg.sv
common/div_if.sv
divider/divider_control.sv
divider/divider.sv
rtl/div_regs.sv
rtl/div_top.sv
tests/div_tb.sv

// ==== rtl/div_regs.sv ====
`timescale 1ns/1ps

module div_regs
    import div_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [31:0]           wb_adr,
    input  logic [data_width-1:0] wb_dat_w,
    output logic [data_width-1:0] wb_dat_r,
    output logic                  wb_ack,
    output logic                  irq,
    div_if.regs                   regs
);

    logic                  bus_req;
    logic                  wr_en;
    logic                  ctrl_wr;
    dividend_t             dividend_q;
    divisor_t              divisor_q;
    logic                  start_q;
    logic                  signed_q;
    quotient_t             quot_q;
    quotient_t             rem_q;
    logic                  zero_q;
    logic                  ovf_q;
    logic                  done_q;
    logic [data_width-1:0] ctrl_word;
    logic [data_width-1:0] status_word;
    logic [data_width-1:0] rd_data;

    assign bus_req = wb_cyc && wb_stb && !wb_ack;
    assign wr_en   = wb_cyc && wb_stb && wb_ack && wb_we;  // Write lands in the ack cycle
    assign ctrl_wr = wr_en && (wb_adr == reg_ctrl);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            start_q  <= 1'b0;
            signed_q <= 1'b0;
        end else begin
            wb_ack  <= bus_req;
            start_q <= ctrl_wr && wb_dat_w[ctrl_start_bit];
            if (ctrl_wr)
                signed_q <= wb_dat_w[ctrl_signed_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && (wb_adr == reg_dividend))
            dividend_q <= wb_dat_w;
        if (wr_en && (wb_adr == reg_divisor))
            divisor_q <= wb_dat_w;
        if (regs.done) begin
            quot_q <= regs.quotient;
            rem_q  <= regs.remainder;
        end
    end

    // Sticky completion flags, cleared by the next start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
            zero_q <= 1'b0;
            ovf_q  <= 1'b0;
        end else if (start_q) begin
            done_q <= 1'b0;
            zero_q <= 1'b0;
            ovf_q  <= 1'b0;
        end else if (regs.done) begin
            done_q <= 1'b1;
            zero_q <= regs.div_zero;
            ovf_q  <= regs.sign_overflow;
        end
    end

    assign irq = done_q || regs.done;

    always_comb begin
        ctrl_word                  = '0;
        ctrl_word[ctrl_signed_bit] = signed_q;

        status_word                      = '0;
        status_word[status_busy_bit]     = regs.busy;
        status_word[status_done_bit]     = irq;
        status_word[status_div_zero_bit] = regs.done ? regs.div_zero : zero_q;
        status_word[status_overflow_bit] = regs.done ? regs.sign_overflow : ovf_q;
    end

    always_comb begin
        case (wb_adr)
            reg_dividend:  rd_data = dividend_q;
            reg_divisor:   rd_data = divisor_q;
            reg_ctrl:      rd_data = ctrl_word;
            reg_status:    rd_data = status_word;
            reg_quotient:  rd_data = regs.done ? regs.quotient : quot_q;
            reg_remainder: rd_data = regs.done ? regs.remainder : rem_q;
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus_req)
            wb_dat_r <= rd_data;
    end

    assign regs.start         = start_q;
    assign regs.dividend      = dividend_q;
    assign regs.divisor       = divisor_q;
    assign regs.inputs_signed = signed_q;

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

endmodule

// ==== rtl/div_top.sv ====
`timescale 1ns/1ps

module div_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        irq
);

    div_if div_bus ();

    div_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .irq      (irq),
        .regs     (div_bus)
    );

    divider u_divider (
        .clk   (clk),
        .rst_n (rst_n),
        .core  (div_bus)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module div_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vdiv_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tests/div_tb_tasks.svh ====
`ifndef DIV_TB_TASKS_SVH
`define DIV_TB_TASKS_SVH

localparam int bus_limit  = 20;
localparam int done_limit = 100;

task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t: %s did not arrive in time", $time, what);
    $display("Test failed");
    $finish;
endtask

// Classic cycle held through the ack cycle
task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                         output logic [31:0] rdata);
    int n;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    n = 0;
    while (!wb_ack && n < bus_limit) begin
        @(negedge clk);
        n++;
    end
    if (!wb_ack) begin
        stop_on_timeout("bus ack");
    end else begin
        ack_cycle = cycle;
        rdata     = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    end
endtask

task automatic bus_write(input logic [31:0] adr, input logic [31:0] data);
    logic [31:0] ignored;
    bus_cycle(1'b1, adr, data, ignored);
endtask

task automatic bus_read(input logic [31:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'h0, data);
endtask

// First negedge skips a stale irq from the previous run
task automatic wait_irq(output int rise_cycle);
    int n;
    n = 0;
    @(negedge clk);
    while (!irq && n < done_limit) begin
        @(negedge clk);
        n++;
    end
    if (!irq)
        stop_on_timeout("irq");
    else
        rise_cycle = cycle;
endtask

// Remainder in the upper word and quotient in the lower word
function automatic logic [63:0] expected_result(input logic [31:0] a, input logic [31:0] b,
                                                input logic sgn);
    if (b == 32'h0)
        return {a, 32'hffff_ffff};
    if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff)
        return {32'h0, 32'h8000_0000};
    if (sgn)
        return {$signed(a) % $signed(b), $signed(a) / $signed(b)};
    return {a % b, a / b};
endfunction

`endif

// ==== tests/div_tb.sv ====
`timescale 1ns/1ps

module div_tb
    import div_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        irq;
    integer      seed = 32'h1f9b_bdb7;
    int          cycle = 0;
    int          ack_cycle = 0;
    int          errors = 0;
    int          mark = 0;
    int          passed = 0;
    int          failed = 0;

    `include "div_tb_tasks.svh"

    div_top u_div_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .irq      (irq)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else begin
            $display("Bus error at %0t: ack stayed high for two cycles", $time);
            errors++;
        end

    a_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_cyc && wb_stb) |=> wb_ack)
        else begin
            $display("Bus error at %0t: ack did not follow the request by one cycle", $time);
            errors++;
        end

    a_ack_requested: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_cyc && wb_stb)
        else begin
            $display("Bus error at %0t: ack without an active cycle", $time);
            errors++;
        end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !wb_ack && !irq)
        else begin
            $display("Reset error at %0t: ack or irq high after reset", $time);
            errors++;
        end

    // irq only drops two cycles after a start write lands
    a_irq_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(irq) |-> $past(wb_ack && wb_we && wb_adr == reg_ctrl && wb_dat_w[ctrl_start_bit], 2))
        else begin
            $display("Irq error at %0t: irq dropped without a new start", $time);
            errors++;
        end

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else begin
            $display("Check failed at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            passed++;
            $display("[%0t] %s: pass", $time, name);
        end else begin
            failed++;
            $display("[%0t] %s: FAIL with %0d errors", $time, name, errors - mark);
        end
        mark = errors;
    endtask

    task automatic run_division(input logic [31:0] a, input logic [31:0] b, input logic sgn,
                                output logic [31:0] q, output logic [31:0] r);
        logic [63:0] exp;
        logic [31:0] exp_status;
        logic [31:0] rd;
        int          start_ack;
        int          rise;
        exp        = expected_result(a, b, sgn);
        exp_status = '0;
        exp_status[status_done_bit]     = 1'b1;
        exp_status[status_div_zero_bit] = (b == 32'h0);
        exp_status[status_overflow_bit] = sgn && a == 32'h8000_0000 && b == 32'hffff_ffff;
        bus_write(reg_dividend, a);
        bus_write(reg_divisor, b);
        bus_write(reg_ctrl, {30'b0, sgn, 1'b1});
        start_ack = ack_cycle;
        wait_irq(rise);
        check_equal("irq latency", rise - start_ack, 35);
        bus_read(reg_status, rd);
        check_equal("status", rd, exp_status);
        bus_read(reg_quotient, q);
        check_equal("quotient", q, exp[31:0]);
        bus_read(reg_remainder, r);
        check_equal("remainder", r, exp[63:32]);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] q;
        logic [31:0] r;
        logic [31:0] rd;
        logic [63:0] exp;
        int          start_ack;
        int          rise;
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 32'h0;
        wb_dat_w = 32'h0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed) >> (4 * i);  // Shrinking divisors
            if (b == 32'h0)
                b = 32'h1;
            run_division(a, b, 1'b0, q, r);
            check_true(r < b, "unsigned remainder not below divisor");
        end
        end_test("unsigned random");

        for (int i = 0; i < 4; i++) begin
            a = $random(seed) & 32'h7fff_ffff;
            b = ($random(seed) & 32'h0000_ffff) | 32'h1;
            if (i[0])
                a = -a;
            if (i[1])
                b = -b;
            run_division(a, b, 1'b1, q, r);
            check_true(r == 32'h0 || r[31] == a[31], "remainder sign differs from dividend");
        end
        end_test("signed sign combinations");

        run_division(32'h1234_5678, 32'h0, 1'b0, q, r);
        run_division(32'hfedc_ba98, 32'h0, 1'b1, q, r);
        end_test("division by zero");

        run_division(32'h8000_0000, 32'hffff_ffff, 1'b1, q, r);
        end_test("signed overflow");

        a = $random(seed);
        b = ($random(seed) & 32'h00ff_ffff) | 32'h1;
        exp = expected_result(a, b, 1'b0);
        bus_write(reg_dividend, a);
        bus_write(reg_divisor, b);
        bus_write(reg_ctrl, 32'h1);
        start_ack = ack_cycle;
        bus_read(reg_status, rd);
        check_equal("status while busy", rd, 32'h1);
        bus_write(reg_divisor, b + 32'h3);  // Second start mid-run
        bus_write(reg_ctrl, 32'h1);
        wait_irq(rise);
        check_equal("irq latency", rise - start_ack, 35);
        bus_read(reg_status, rd);
        check_equal("status after done", rd, 32'h2);
        bus_read(reg_quotient, rd);
        check_equal("quotient after restart", rd, exp[31:0]);
        bus_read(reg_remainder, rd);
        check_equal("remainder after restart", rd, exp[63:32]);
        end_test("handshake and latency");

        a = $random(seed);
        b = $random(seed);
        bus_write(reg_dividend, a);
        bus_write(reg_divisor, b);
        bus_read(reg_dividend, rd);
        check_equal("dividend readback", rd, a);
        bus_read(reg_divisor, rd);
        check_equal("divisor readback", rd, b);
        bus_read(32'h18, rd);
        check_equal("unmapped 0x18", rd, 32'h0);
        bus_read(32'h100, rd);
        check_equal("unmapped 0x100", rd, 32'h0);
        end_test("bus rules");

        $display("Summary: %0d tests passed, %0d with errors, %0d check errors",
                 passed, failed, errors);
        if (failed == 0 && errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
